//--- filelist.f
xbar_mux_pkg.sv
logic/lock_tracker.sv
logic/rr_arbiter.sv
logic/grant_control.sv
logic/payload_mux.sv
logic/xbar_mux.sv
verification/xbar_mux_chk.sv
verification/xbar_mux_tb.sv

//--- Makefile
# Verilator build and run for the packet mux testbench

TOP := xbar_mux_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- verification/xbar_mux_tb.sv
// Testbench for the packet mux that drives packet streams on all sinks and checks the source order
module xbar_mux_tb import xbar_mux_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Packets per sink and per round
    localparam int NUM_PKTS   = 6;
    localparam int TOTAL_PKTS = 2 * NUM_PKTS;

    logic     clk;
    logic     reset;
    sel_vec_t sink_valid;
    data_t    sink_data [NUM_INPUTS];
    channel_t sink_channel [NUM_INPUTS];
    sel_vec_t sink_startofpacket;
    sel_vec_t sink_endofpacket;
    sel_vec_t sink_ready;
    logic     src_valid;
    data_t    src_data;
    channel_t src_channel;
    logic     src_startofpacket;
    logic     src_endofpacket;
    logic     src_ready;

    // Stimulus state
    int seed = 38252;
    int pkt_limit;
    bit rand_ready;
    int pkt_idx [NUM_INPUTS];
    int beat_idx [NUM_INPUTS];
    int sent_seq [NUM_INPUTS];

    // Monitor state
    int rx_seq [NUM_INPUTS];
    int cur_sink;
    int last_sink;
    int exp_sink;
    bit in_pkt;
    int errors;
    int beats_rx;

    xbar_mux u_xbar_mux (.*);

    bind xbar_mux xbar_mux_chk u_xbar_mux_chk (
        .clk             (clk),
        .reset           (reset),
        .grant           (grant),
        .sink_valid      (sink_valid),
        .sink_channel    (sink_channel),
        .sink_ready      (sink_ready),
        .src_valid       (src_valid),
        .src_channel     (src_channel),
        .src_endofpacket (src_endofpacket),
        .src_ready       (src_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ------------------------------------------------------------------------
    // Packet lists and reference model
    // ------------------------------------------------------------------------

    // Lengths of 1 to 4 beats fixed per sink and packet
    function automatic int pkt_len(int s, int p);
        return 1 + ((s * 3 + p * 5 + p / 3) % 4);
    endfunction

    // Locks only in the second round and never on a sink's final packet
    function automatic bit pkt_locked(int s, int p);
        return (p >= NUM_PKTS) && (p != TOTAL_PKTS - 1) && ((s + p) % 3 == 0);
    endfunction

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int s = 0; s < NUM_INPUTS; s++) begin
            for (int p = 0; p < TOTAL_PKTS; p++) begin
                sum += pkt_len(s, p);
            end
        end
        return sum;
    endfunction

    // Sinks that still have packets to offer all hold valid
    function automatic sel_vec_t pending_vec();
        sel_vec_t v;
        for (int s = 0; s < NUM_INPUTS; s++) begin
            v[s] = pkt_idx[s] < pkt_limit;
        end
        return v;
    endfunction

    // Held lock keeps the sink
    // Otherwise the first requester after the last one wins
    function automatic int next_sink(int last, bit held, sel_vec_t req);
        int idx;
        if (held) begin
            return last;
        end
        for (int k = 1; k <= NUM_INPUTS; k++) begin
            idx = (last + k) % NUM_INPUTS;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic bit all_done();
        for (int s = 0; s < NUM_INPUTS; s++) begin
            if (pkt_idx[s] < pkt_limit) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Sink drivers
    // ------------------------------------------------------------------------

    always @(posedge clk) begin : drive_sinks
        sel_vec_t fire;
        fire = sink_valid & sink_ready;
        #1;
        for (int s = 0; s < NUM_INPUTS; s++) begin
            if (fire[s]) begin
                sent_seq[s]++;
                if (beat_idx[s] == pkt_len(s, pkt_idx[s]) - 1) begin
                    beat_idx[s] = 0;
                    pkt_idx[s]++;
                end else begin
                    beat_idx[s]++;
                end
            end
            sink_data[s] = '0;
            if (pkt_idx[s] < pkt_limit) begin
                sink_valid[s] = 1'b1;
                sink_data[s][15:0] = sent_seq[s][15:0];
                sink_data[s][31:28] = s[3:0];
                sink_data[s][LOCK_BIT] = pkt_locked(s, pkt_idx[s]);
                sink_startofpacket[s] = beat_idx[s] == 0;
                sink_endofpacket[s] = beat_idx[s] == pkt_len(s, pkt_idx[s]) - 1;
            end else begin
                sink_valid[s] = 1'b0;
                sink_startofpacket[s] = 1'b0;
                sink_endofpacket[s] = 1'b0;
            end
        end
        // Ready high about three beats in four
        src_ready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // ------------------------------------------------------------------------
    // Source compare
    // ------------------------------------------------------------------------

    always @(posedge clk) begin : check_source
        int ch;
        sel_vec_t req;
        if (!reset && src_valid && src_ready) begin
            beats_rx++;
            ch = int'(src_channel) % NUM_INPUTS;
            if (src_startofpacket) begin
                assert (!in_pkt) else begin
                    errors++;
                    $display("Start of packet at %0t while a packet was still open", $time);
                end
                // No sink was waiting at the previous end of packet
                if (exp_sink < 0) begin
                    exp_sink = next_sink(last_sink, 1'b0, pending_vec());
                end
                assert (int'(src_channel) == exp_sink) else begin
                    errors++;
                    $display("Error at %0d ns: src_channel = %0d, expected %0d",
                             $time, src_channel, exp_sink);
                end
                cur_sink = ch;
                in_pkt = 1'b1;
            end else begin
                assert (in_pkt) else begin
                    errors++;
                    $display("Beat at %0t arrived without a start of packet", $time);
                end
                assert (int'(src_channel) == cur_sink) else begin
                    errors++;
                    $display("Error at %0d ns: src_channel = %0d, expected %0d",
                             $time, src_channel, cur_sink);
                end
            end
            assert (src_data[15:0] == rx_seq[ch][15:0]) else begin
                errors++;
                $display("Error at %0d ns: src_data[15:0] = %0d, expected %0d",
                         $time, src_data[15:0], rx_seq[ch][15:0]);
            end
            rx_seq[ch]++;
            if (src_endofpacket) begin
                in_pkt = 1'b0;
                last_sink = cur_sink;
                // A sink stops requesting once its final packet ends
                req = pending_vec();
                if (pkt_idx[cur_sink] == pkt_limit - 1) begin
                    req[cur_sink] = 1'b0;
                end
                exp_sink = next_sink(cur_sink, pkt_locked(cur_sink, pkt_idx[cur_sink]), req);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        reset = 1'b1;
        src_ready = 1'b0;
        rand_ready = 1'b0;
        pkt_limit = 0;
        sink_valid = '0;
        sink_startofpacket = '0;
        sink_endofpacket = '0;
        for (int s = 0; s < NUM_INPUTS; s++) begin
            sink_data[s] = '0;
            sink_channel[s] = channel_t'(s);
            pkt_idx[s] = 0;
            beat_idx[s] = 0;
            sent_seq[s] = 0;
            rx_seq[s] = 0;
        end
        last_sink = NUM_INPUTS - 1;
        exp_sink = -1;
        in_pkt = 1'b0;
        errors = 0;
        beats_rx = 0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;

        // Quiet after reset
        repeat (3) begin
            @(posedge clk);
            assert (!src_valid && sink_ready == '0) else begin
                errors++;
                $display("Source valid or sink ready raised at %0t with no sink valid", $time);
            end
        end

        // Round one without locks or back-pressure
        pkt_limit = NUM_PKTS;
        @(posedge clk);
        assert (!src_valid) else begin
            errors++;
            $display("Source valid at %0t in the same cycle as sink valid", $time);
        end
        @(posedge clk);
        assert (src_valid) else begin
            errors++;
            $display("First beat missing one cycle after sink valid at %0t", $time);
        end
        while (!all_done()) @(posedge clk);
        repeat (4) @(posedge clk);

        // Round two with locks and random ready
        rand_ready = 1'b1;
        pkt_limit = TOTAL_PKTS;
        while (!all_done()) @(posedge clk);
        repeat (4) @(posedge clk);

        for (int s = 0; s < NUM_INPUTS; s++) begin
            assert (rx_seq[s] == sent_seq[s]) else begin
                errors++;
                $display("Sink %0d sent %0d beats but %0d reached the source",
                         s, sent_seq[s], rx_seq[s]);
            end
        end
        $display("Errors: %0d, beats received: %0d of %0d", errors, beats_rx, total_beats());
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog allows twenty cycles per beat plus reset and round gaps
    initial begin : watchdog
        int limit;
        limit = total_beats() * 20 + 40;
        repeat (limit) @(posedge clk);
        $display("Timeout: packets did not all arrive within %0d cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- verification/xbar_mux_chk.sv
// Bound checker for the packet mux that asserts the grant and ready rules on the top level
module xbar_mux_chk import xbar_mux_pkg::*; (
    input logic     clk,
    input logic     reset,
    input sel_vec_t grant,
    input sel_vec_t sink_valid,
    input channel_t sink_channel [NUM_INPUTS],
    input sel_vec_t sink_ready,
    input logic     src_valid,
    input channel_t src_channel,
    input logic     src_endofpacket,
    input logic     src_ready
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // Grant rules
    // ------------------------------------------------------------------------

    // At most one sink owns the source
    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant)) else $error("grant is not one-hot or zero");

    // A waiting beat or a beat before the end of packet keeps the grant
    grant_stable: assert property (@(posedge clk) disable iff (reset)
        src_valid && !(src_ready && src_endofpacket) |=> $stable(grant))
        else $error("grant changed inside a packet");

    // ------------------------------------------------------------------------
    // Ready rules
    // ------------------------------------------------------------------------

    // A ready sink is the one whose beat is on the source
    // Back-pressure closes every sink
    for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_ready
        ready_granted: assert property (@(posedge clk) disable iff (reset)
            sink_ready[i] |-> src_ready && src_valid == sink_valid[i] &&
                              src_channel == sink_channel[i])
            else $error("sink_ready on a sink whose beat is not on the source");
    end

endmodule

//--- logic/xbar_mux.sv
// Top level of the command crossbar packet mux, merging the sink ports onto one source port
module xbar_mux import xbar_mux_pkg::*; (
    input  logic     clk,
    input  logic     reset,

    // ------------------------------------------------------------------------
    // Sinks
    // ------------------------------------------------------------------------
    input  sel_vec_t sink_valid,
    input  data_t    sink_data [NUM_INPUTS],
    input  channel_t sink_channel [NUM_INPUTS],
    input  sel_vec_t sink_startofpacket,
    input  sel_vec_t sink_endofpacket,
    output sel_vec_t sink_ready,

    // ------------------------------------------------------------------------
    // Source
    // ------------------------------------------------------------------------
    output logic     src_valid,
    output data_t    src_data,
    output channel_t src_channel,
    output logic     src_startofpacket,
    output logic     src_endofpacket,
    input  logic     src_ready
);

    // Lock flags of the current sink beats
    sel_vec_t lock;

    // Valid or locked per sink
    sel_vec_t request;

    // Combinational arbiter choice
    sel_vec_t next_grant;

    // Registered grant
    sel_vec_t grant;

    // Take the arbiter choice on this clock
    logic update_grant;

    // Input side
    lock_tracker u_lock_tracker (
        .clk        (clk),
        .reset      (reset),
        .sink_valid (sink_valid),
        .sink_data  (sink_data),
        .next_grant (next_grant),
        .lock       (lock),
        .request    (request)
    );

    // Arbitration
    rr_arbiter u_rr_arbiter (
        .clk          (clk),
        .reset        (reset),
        .request      (request),
        .update_grant (update_grant),
        .next_grant   (next_grant)
    );

    // Grant register and packet tracking
    grant_control u_grant_control (
        .clk             (clk),
        .reset           (reset),
        .next_grant      (next_grant),
        .lock            (lock),
        .src_valid       (src_valid),
        .src_ready       (src_ready),
        .src_endofpacket (src_endofpacket),
        .grant           (grant),
        .update_grant    (update_grant)
    );

    // Output side whose src_valid also loops back to the grant control
    payload_mux u_payload_mux (
        .grant              (grant),
        .sink_valid         (sink_valid),
        .sink_data          (sink_data),
        .sink_channel       (sink_channel),
        .sink_startofpacket (sink_startofpacket),
        .sink_endofpacket   (sink_endofpacket),
        .src_ready          (src_ready),
        .sink_ready         (sink_ready),
        .src_valid          (src_valid),
        .src_data           (src_data),
        .src_channel        (src_channel),
        .src_startofpacket  (src_startofpacket),
        .src_endofpacket    (src_endofpacket)
    );

endmodule

//--- logic/payload_mux.sv
// Output side of the packet mux that steers the granted sink beat to the source and gates ready
module payload_mux import xbar_mux_pkg::*; (
    input  sel_vec_t grant,
    input  sel_vec_t sink_valid,
    input  data_t    sink_data [NUM_INPUTS],
    input  channel_t sink_channel [NUM_INPUTS],
    input  sel_vec_t sink_startofpacket,
    input  sel_vec_t sink_endofpacket,
    input  logic     src_ready,
    output sel_vec_t sink_ready,
    output logic     src_valid,
    output data_t    src_data,
    output channel_t src_channel,
    output logic     src_startofpacket,
    output logic     src_endofpacket
);

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------

    // Back-pressure reaches the granted sink only
    assign sink_ready = {NUM_INPUTS{src_ready}} & grant;

    // Source is valid whenever the granted sink is
    assign src_valid = |(grant & sink_valid);

    // ------------------------------------------------------------------------
    // Beat select
    // ------------------------------------------------------------------------

    // Packet markers of one bit each
    assign src_startofpacket = |(grant & sink_startofpacket);
    assign src_endofpacket   = |(grant & sink_endofpacket);

    // And-or sum of products over all sinks
    // Grant is one-hot or zero, so at most one term contributes
    always_comb begin
        src_data    = '0;
        src_channel = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            src_data    = src_data | (sink_data[i] & {DATA_W{grant[i]}});
            src_channel = src_channel | (sink_channel[i] & {CHANNEL_W{grant[i]}});
        end
    end

endmodule

//--- logic/grant_control.sv
// Grant control for the packet mux that tracks packets and holds the registered grant vector
module grant_control import xbar_mux_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  sel_vec_t next_grant,
    input  sel_vec_t lock,
    input  logic     src_valid,
    input  logic     src_ready,
    input  logic     src_endofpacket,
    output sel_vec_t grant,
    output logic     update_grant
);

    // Accepted end of packet that releases the grant
    logic last_cycle;

    // Set from the first valid beat until the releasing end of packet
    logic packet_in_progress;

    // ------------------------------------------------------------------------
    // End of grant detection
    // ------------------------------------------------------------------------

    // Eop beat accepted on the source
    // A set lock flag on the granted sink keeps the grant for its next packet
    assign last_cycle = src_valid & src_ready & src_endofpacket &
                        ~(|(lock & grant));

    // ------------------------------------------------------------------------
    // Packet tracking
    // ------------------------------------------------------------------------

    // Release wins over a new valid beat in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            packet_in_progress <= 1'b0;
        end else if (last_cycle) begin
            packet_in_progress <= 1'b0;
        end else if (src_valid) begin
            packet_in_progress <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Grant update
    // ------------------------------------------------------------------------

    // Grant is registered, so the decision is taken one cycle ahead
    // Idle mux keeps sampling the arbiter until somebody requests
    // The final beat hands over with no bubble in between
    assign update_grant = (~packet_in_progress & ~src_valid) | last_cycle;

    // Saved grant stays stable for the whole packet
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant <= '0;
        end else if (update_grant) begin
            grant <= next_grant;
        end
    end

endmodule

//--- logic/rr_arbiter.sv
// Round-robin arbiter for the packet mux with a registered one-hot top-priority pointer
module rr_arbiter import xbar_mux_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  sel_vec_t request,
    input  logic     update_grant,
    output sel_vec_t next_grant
);

    // One-hot pointer to the sink with highest priority
    sel_vec_t top_priority;

    // Request vector repeated twice so the search can wrap around
    logic [2*NUM_INPUTS-1:0] double_request;

    // Winner in either half of the doubled vector
    logic [2*NUM_INPUTS-1:0] double_grant;

    // ------------------------------------------------------------------------
    // Grant search
    // ------------------------------------------------------------------------

    assign double_request = {request, request};

    // Subtracting the pointer clears the lowest requester at or above it
    // and sets every bit below, so the mask leaves exactly that requester
    // Zero request gives zero grant
    assign double_grant = double_request &
                          ~(double_request - {{NUM_INPUTS{1'b0}}, top_priority});

    // Fold the wrapped half back onto the sink positions
    assign next_grant = double_grant[NUM_INPUTS-1:0] |
                        double_grant[2*NUM_INPUTS-1:NUM_INPUTS];

    // ------------------------------------------------------------------------
    // Pointer update
    // ------------------------------------------------------------------------

    // Sink 0 starts with highest priority
    // On a real grant the pointer moves to the position after the winner
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            top_priority <= sel_vec_t'(1);
        end else if (update_grant && (|next_grant)) begin
            top_priority <= {next_grant[NUM_INPUTS-2:0], next_grant[NUM_INPUTS-1]};
        end
    end

endmodule

//--- logic/lock_tracker.sv
// Input side of the packet mux that pulls lock flags from sink data and builds the arbiter request
module lock_tracker import xbar_mux_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  sel_vec_t sink_valid,
    input  data_t    sink_data [NUM_INPUTS],
    input  sel_vec_t next_grant,
    output sel_vec_t lock,
    output sel_vec_t request
);

    // Lock flags of the sink the arbiter chose last clock
    sel_vec_t locked;

    // ------------------------------------------------------------------------
    // Lock extraction
    // ------------------------------------------------------------------------

    // One flag per sink straight from the current beat
    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            lock[i] = sink_data[i][LOCK_BIT];
        end
    end

    // Only the chosen sink can hold a lock
    // Updated every clock as the grant logic decides when it matters
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            locked <= '0;
        end else begin
            locked <= next_grant & lock;
        end
    end

    // ------------------------------------------------------------------------
    // Request vector
    // ------------------------------------------------------------------------

    // A locked sink keeps requesting in the gap between its packets
    assign request = sink_valid | locked;

endmodule

//--- xbar_mux_pkg.sv
// Shared constants and vector types for the command crossbar packet mux, imported by all RTL
package xbar_mux_pkg;

    // ------------------------------------------------------------------------
    // Port count and field sizes
    // ------------------------------------------------------------------------

    // Sink ports competing for the single source
    localparam int NUM_INPUTS = 4;

    // Data beat width
    localparam int DATA_W = 32;

    // Channel field width
    localparam int CHANNEL_W = 8;

    // Transaction lock flag carried inside the data field
    localparam int LOCK_BIT = 24;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------

    // One bit per sink for valid, eop, lock, request and grant
    typedef logic [NUM_INPUTS-1:0] sel_vec_t;

    // One data beat
    typedef logic [DATA_W-1:0] data_t;

    // Channel field of a beat
    typedef logic [CHANNEL_W-1:0] channel_t;

endpackage
